// ==== rtl/net_msg_pkg.sv ====
/* flit format for the ring network
   field widths and bit positions of a single-flit message */

package net_msg_pkg;

  // field widths
  localparam int dest_nbits    = 3;
  localparam int src_nbits     = 3;
  localparam int opaque_nbits  = 2;
  localparam int payload_nbits = 8;

  // whole flit, fields packed from the top down
  localparam int msg_nbits = dest_nbits + src_nbits + opaque_nbits + payload_nbits;

  // dest sits in the top bits
  localparam int dest_lsb = msg_nbits - dest_nbits;

  // source router id right below dest
  localparam int src_lsb = dest_lsb - src_nbits;

  // opaque tag, then payload from bit 0 up
  localparam int opaque_lsb = src_lsb - opaque_nbits;

endpackage

// ==== rtl/router_cfg_pkg.sv ====
/* ring size, route codes, queue depth and free-slot count width */

package router_cfg_pkg;

  // routers on the ring
  localparam int num_routers = 8;

  // prev, term, next
  localparam int num_ports = 3;

  // route codes double as port indices
  localparam logic [1:0] route_prev = 2'd0;
  localparam logic [1:0] route_term = 2'd1;
  localparam logic [1:0] route_next = 2'd2;

  // entries per input queue
  localparam int queue_depth = 2;

  // width of a neighbor free-slot count
  localparam int free_nbits = 2;

endpackage

// ==== rtl/input_queue.sv ====
/* input buffer of one router port
   small circular FIFO with val/rdy on both sides, no bypass */

module input_queue (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              enq_val,
  output logic                              enq_rdy,
  input  logic [net_msg_pkg::msg_nbits-1:0] enq_msg,
  output logic                              deq_val,
  input  logic                              deq_rdy,
  output logic [net_msg_pkg::msg_nbits-1:0] deq_msg
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  // storage, head at rd_ptr
  logic [msg_nbits-1:0]             mem [queue_depth];
  logic [$clog2(queue_depth)-1:0]   wr_ptr;
  logic [$clog2(queue_depth)-1:0]   rd_ptr;
  logic [$clog2(queue_depth+1)-1:0] count;
  logic                             enq_fire;
  logic                             deq_fire;

  assign enq_rdy  = (count < queue_depth);
  assign deq_val  = (count != '0);
  assign deq_msg  = mem[rd_ptr];
  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  // pointers wrap at the last entry
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == queue_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == queue_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // enq and deq together leave the count alone
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/adaptive_route_compute.sv ====
/* output choice for a flit injected by the local terminal
   shorter way round the ring, ties broken by neighbor free space */

module adaptive_route_compute #(
  parameter int router_id = 0
) (
  input  logic [net_msg_pkg::dest_nbits-1:0]    dest,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free_prev,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free_next,
  output logic [1:0]                            route
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  // one extra bit so a full lap fits
  logic [dest_nbits:0] dist_up;
  logic [dest_nbits:0] dist_down;

  always_comb begin
    // hops going up through next, modulo ring size
    dist_up   = (dest_nbits+1)'((num_routers + dest - router_id) % num_routers);
    // hops going down through prev
    dist_down = (dest_nbits+1)'(num_routers) - dist_up;

    if (dist_up == '0) begin
      // already home
      route = route_term;
    end else if (dist_up < dist_down) begin
      route = route_next;
    end else if (dist_down < dist_up) begin
      route = route_prev;
    end else if (nbr_free_prev > nbr_free_next) begin
      // halfway round, prev only if it has strictly more room
      route = route_prev;
    end else begin
      route = route_next;
    end
  end

endmodule

// ==== rtl/input_terminal_ctrl.sv ====
/* terminal input control
   head flit to output requests, bubble rule on ring injection */

module input_terminal_ctrl #(
  parameter int router_id = 0
) (
  input  logic                                  val,
  input  logic [net_msg_pkg::msg_nbits-1:0]     msg,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free_prev,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free_next,
  output logic [router_cfg_pkg::num_ports-1:0]  reqs,
  input  logic [router_cfg_pkg::num_ports-1:0]  grants,
  output logic                                  deq_rdy
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  logic [1:0] route;

  adaptive_route_compute #(
    .router_id (router_id)
  ) route_compute (
    .dest          (msg[dest_lsb +: dest_nbits]),
    .nbr_free_prev (nbr_free_prev),
    .nbr_free_next (nbr_free_next),
    .route         (route)
  );

  // injection onto the ring leaves at least one slot downstream
  // so transit flits can always move
  always_comb begin
    reqs = '0;
    if (val) begin
      case (route)
        route_prev: reqs[route_prev] = (nbr_free_prev > 1);
        route_term: reqs[route_term] = 1'b1;
        route_next: reqs[route_next] = (nbr_free_next > 1);
        default:    reqs = '0;
      endcase
    end
  end

  // pop when our request won
  assign deq_rdy = |(reqs & grants);

endmodule

// ==== rtl/input_ring_ctrl.sv ====
/* transit input control for the prev or next port
   eject at home, otherwise keep going the same way */

module input_ring_ctrl #(
  parameter int         router_id = 0,
  parameter logic [1:0] cont_port = router_cfg_pkg::route_next
) (
  input  logic                                  val,
  input  logic [net_msg_pkg::msg_nbits-1:0]     msg,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free,
  output logic [router_cfg_pkg::num_ports-1:0]  reqs,
  input  logic [router_cfg_pkg::num_ports-1:0]  grants,
  output logic                                  deq_rdy
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  always_comb begin
    reqs = '0;
    if (val) begin
      if (msg[dest_lsb +: dest_nbits] == router_id) begin
        reqs[route_term] = 1'b1;
      end else begin
        // ring traffic needs just one free slot downstream
        reqs[cont_port] = (nbr_free > 0);
      end
    end
  end

  // pop when our request won
  assign deq_rdy = |(reqs & grants);

endmodule

// ==== rtl/switch_alloc.sv ====
/* switch allocator
   one round-robin arbiter per output, gated by that output's rdy */

module switch_alloc (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [router_cfg_pkg::num_ports-1:0] reqs_p0,
  input  logic [router_cfg_pkg::num_ports-1:0] reqs_p1,
  input  logic [router_cfg_pkg::num_ports-1:0] reqs_p2,
  input  logic                                 out_rdy_p0,
  input  logic                                 out_rdy_p1,
  input  logic                                 out_rdy_p2,
  output logic [router_cfg_pkg::num_ports-1:0] grants_p0,
  output logic [router_cfg_pkg::num_ports-1:0] grants_p1,
  output logic [router_cfg_pkg::num_ports-1:0] grants_p2
);
  import router_cfg_pkg::*;

  // reqs indexed by input, grants indexed by output
  logic [num_ports-1:0] req_by_in    [num_ports];
  logic [num_ports-1:0] grant_by_out [num_ports];
  logic [num_ports-1:0] out_rdy;

  assign req_by_in[0] = reqs_p0;
  assign req_by_in[1] = reqs_p1;
  assign req_by_in[2] = reqs_p2;
  assign out_rdy      = {out_rdy_p2, out_rdy_p1, out_rdy_p0};

  for (genvar o = 0; o < num_ports; o++) begin : g_arb
    logic [num_ports-1:0]         req_col;
    logic [num_ports-1:0]         grant;
    logic [$clog2(num_ports)-1:0] ptr;
    logic [$clog2(num_ports)-1:0] winner;
    logic                         found;

    // inputs asking for this output
    for (genvar i = 0; i < num_ports; i++) begin : g_col
      assign req_col[i] = req_by_in[i][o];
    end

    // scan from ptr, first requester wins
    always_comb begin
      int idx;
      found  = 1'b0;
      winner = ptr;
      for (int k = 0; k < num_ports; k++) begin
        idx = (int'(ptr) + k) % num_ports;
        if (!found && out_rdy[o] && req_col[idx]) begin
          found  = 1'b1;
          winner = idx[$clog2(num_ports)-1:0];
        end
      end
      grant = '0;
      if (found) begin
        grant[winner] = 1'b1;
      end
    end

    // winner drops to lowest priority
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        ptr <= '0;
      end else if (found) begin
        ptr <= (winner == num_ports - 1) ? '0 : winner + 1'b1;
      end
    end

    assign grant_by_out[o] = grant;
  end

  assign grants_p0 = grant_by_out[0];
  assign grants_p1 = grant_by_out[1];
  assign grants_p2 = grant_by_out[2];

endmodule

// ==== rtl/ring_router.sv ====
/* one node of a bidirectional ring
   input queues, route controls, switch allocation and output crossbar */

module ring_router #(
  parameter int router_id = 0
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  in_val_p0,
  input  logic                                  in_val_p1,
  input  logic                                  in_val_p2,
  output logic                                  in_rdy_p0,
  output logic                                  in_rdy_p1,
  output logic                                  in_rdy_p2,
  input  logic [net_msg_pkg::msg_nbits-1:0]     in_msg_p0,
  input  logic [net_msg_pkg::msg_nbits-1:0]     in_msg_p1,
  input  logic [net_msg_pkg::msg_nbits-1:0]     in_msg_p2,
  output logic                                  out_val_p0,
  output logic                                  out_val_p1,
  output logic                                  out_val_p2,
  input  logic                                  out_rdy_p0,
  input  logic                                  out_rdy_p1,
  input  logic                                  out_rdy_p2,
  output logic [net_msg_pkg::msg_nbits-1:0]     out_msg_p0,
  output logic [net_msg_pkg::msg_nbits-1:0]     out_msg_p1,
  output logic [net_msg_pkg::msg_nbits-1:0]     out_msg_p2,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free_prev,
  input  logic [router_cfg_pkg::free_nbits-1:0] nbr_free_next
);
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  // port index equals route code: 0 prev, 1 term, 2 next
  logic [num_ports-1:0] enq_val;
  logic [num_ports-1:0] enq_rdy;
  logic [msg_nbits-1:0] enq_msg       [num_ports];
  logic [num_ports-1:0] head_val;
  logic [num_ports-1:0] head_rdy;
  logic [msg_nbits-1:0] head_msg      [num_ports];
  logic [num_ports-1:0] reqs_by_in    [num_ports];
  logic [num_ports-1:0] grants_by_in  [num_ports];
  logic [num_ports-1:0] grants_by_out [num_ports];
  logic [msg_nbits-1:0] out_mux       [num_ports];

  assign enq_val = {in_val_p2, in_val_p1, in_val_p0};
  assign {in_rdy_p2, in_rdy_p1, in_rdy_p0} = enq_rdy;
  assign enq_msg[0] = in_msg_p0;
  assign enq_msg[1] = in_msg_p1;
  assign enq_msg[2] = in_msg_p2;

  for (genvar p = 0; p < num_ports; p++) begin : g_queue
    input_queue u_queue (
      .clk     (clk),
      .arst_n  (arst_n),
      .enq_val (enq_val[p]),
      .enq_rdy (enq_rdy[p]),
      .enq_msg (enq_msg[p]),
      .deq_val (head_val[p]),
      .deq_rdy (head_rdy[p]),
      .deq_msg (head_msg[p])
    );
  end

  // flits from below continue up to next
  input_ring_ctrl #(
    .router_id (router_id),
    .cont_port (route_next)
  ) u_prev_ctrl (
    .val      (head_val[route_prev]),
    .msg      (head_msg[route_prev]),
    .nbr_free (nbr_free_next),
    .reqs     (reqs_by_in[route_prev]),
    .grants   (grants_by_in[route_prev]),
    .deq_rdy  (head_rdy[route_prev])
  );

  input_terminal_ctrl #(
    .router_id (router_id)
  ) u_term_ctrl (
    .val           (head_val[route_term]),
    .msg           (head_msg[route_term]),
    .nbr_free_prev (nbr_free_prev),
    .nbr_free_next (nbr_free_next),
    .reqs          (reqs_by_in[route_term]),
    .grants        (grants_by_in[route_term]),
    .deq_rdy       (head_rdy[route_term])
  );

  // flits from above continue down to prev
  input_ring_ctrl #(
    .router_id (router_id),
    .cont_port (route_prev)
  ) u_next_ctrl (
    .val      (head_val[route_next]),
    .msg      (head_msg[route_next]),
    .nbr_free (nbr_free_prev),
    .reqs     (reqs_by_in[route_next]),
    .grants   (grants_by_in[route_next]),
    .deq_rdy  (head_rdy[route_next])
  );

  switch_alloc u_alloc (
    .clk        (clk),
    .arst_n     (arst_n),
    .reqs_p0    (reqs_by_in[0]),
    .reqs_p1    (reqs_by_in[1]),
    .reqs_p2    (reqs_by_in[2]),
    .out_rdy_p0 (out_rdy_p0),
    .out_rdy_p1 (out_rdy_p1),
    .out_rdy_p2 (out_rdy_p2),
    .grants_p0  (grants_by_out[0]),
    .grants_p1  (grants_by_out[1]),
    .grants_p2  (grants_by_out[2])
  );

  // allocator speaks per output, controls listen per input
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      for (int o = 0; o < num_ports; o++) begin
        grants_by_in[i][o] = grants_by_out[o][i];
      end
    end
  end

  // one-hot crossbar, at most one grant per output
  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      out_mux[o] = '0;
      for (int i = 0; i < num_ports; i++) begin
        if (grants_by_out[o][i]) begin
          out_mux[o] = out_mux[o] | head_msg[i];
        end
      end
    end
  end

  // a grant implies out_rdy, so val here always completes a transfer
  assign out_val_p0 = |grants_by_out[0];
  assign out_val_p1 = |grants_by_out[1];
  assign out_val_p2 = |grants_by_out[2];
  assign out_msg_p0 = out_mux[0];
  assign out_msg_p1 = out_mux[1];
  assign out_msg_p2 = out_mux[2];

endmodule

// ==== tb/ring_router_properties.sv ====
/* concurrent checks on grants and queue head handshakes
   bound into the router top level */

module ring_router_properties (
  input logic                                                                clk,
  input logic                                                                arst_n,
  input logic [router_cfg_pkg::num_ports-1:0][router_cfg_pkg::num_ports-1:0] gnt,
  input logic [router_cfg_pkg::num_ports-1:0]                                out_rdy,
  input logic [router_cfg_pkg::num_ports-1:0]                                head_val,
  input logic [router_cfg_pkg::num_ports-1:0]                                head_rdy,
  input logic [router_cfg_pkg::num_ports-1:0][net_msg_pkg::msg_nbits-1:0]    head_msg
);
  import router_cfg_pkg::*;

  // gnt and out_rdy are indexed by output
  for (genvar o = 0; o < num_ports; o++) begin : g_out
    // each output serves at most one input per cycle
    grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(gnt[o]))
      else $error("output %0d granted to more than one input", o);

    // a stalled output grants nothing
    grant_needs_rdy: assert property (@(posedge clk) disable iff (!arst_n)
      !out_rdy[o] |-> (gnt[o] == '0))
      else $error("output %0d granted while its rdy was low", o);
  end

  // head signals are indexed by input
  for (genvar i = 0; i < num_ports; i++) begin : g_in
    // a queue head offered to its control holds still until it is taken
    head_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (head_val[i] && !head_rdy[i]) |=> (head_val[i] && $stable(head_msg[i])))
      else $error("input %0d queue head changed while it was waiting", i);
  end

endmodule

bind ring_router ring_router_properties router_checks (
  .clk      (clk),
  .arst_n   (arst_n),
  .gnt      ({grants_by_out[2], grants_by_out[1], grants_by_out[0]}),
  .out_rdy  ({out_rdy_p2, out_rdy_p1, out_rdy_p0}),
  .head_val (head_val),
  .head_rdy (head_rdy),
  .head_msg ({head_msg[2], head_msg[1], head_msg[0]})
);

// ==== tb/ring_router_tb.sv ====
/* testbench for one ring router node
   case-file driver, output monitor, scoreboard per input and report */

module ring_router_tb;
  import net_msg_pkg::*;
  import router_cfg_pkg::*;

  localparam int my_id     = 2;
  localparam int wait_max  = 600;
  localparam int quiet_len = 20;

  logic                  clk;
  logic                  arst_n;
  logic                  in_val  [num_ports];
  logic                  in_rdy  [num_ports];
  logic [msg_nbits-1:0]  in_msg  [num_ports];
  logic                  out_val [num_ports];
  logic [num_ports-1:0]  out_rdy;
  logic [msg_nbits-1:0]  out_msg [num_ports];
  logic [free_nbits-1:0] nbr_free_prev;
  logic [free_nbits-1:0] nbr_free_next;

  // case file columns, one entry per line
  int c_port[$];
  int c_dest[$];
  int c_src[$];
  int c_opq[$];
  int c_pay[$];
  int c_fp[$];
  int c_fn[$];
  int c_stall[$];

  // expected flits per input in queue order, plus flits parked by the bubble rule
  logic [msg_nbits-1:0] exp_msg  [num_ports][$];
  logic [1:0]           exp_port [num_ports][$];
  int                   exp_case [num_ports][$];
  int                   held     [num_ports][$];

  int errors     = 0;
  int delivered  = 0;
  int stall_left = 0;
  int seed       = 38007;
  int cur_fp;
  int cur_fn;
  bit aborted    = 1'b0;

  ring_router #(
    .router_id (my_id)
  ) DUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_val_p0     (in_val[0]),
    .in_val_p1     (in_val[1]),
    .in_val_p2     (in_val[2]),
    .in_rdy_p0     (in_rdy[0]),
    .in_rdy_p1     (in_rdy[1]),
    .in_rdy_p2     (in_rdy[2]),
    .in_msg_p0     (in_msg[0]),
    .in_msg_p1     (in_msg[1]),
    .in_msg_p2     (in_msg[2]),
    .out_val_p0    (out_val[0]),
    .out_val_p1    (out_val[1]),
    .out_val_p2    (out_val[2]),
    .out_rdy_p0    (out_rdy[0]),
    .out_rdy_p1    (out_rdy[1]),
    .out_rdy_p2    (out_rdy[2]),
    .out_msg_p0    (out_msg[0]),
    .out_msg_p1    (out_msg[1]),
    .out_msg_p2    (out_msg[2]),
    .nbr_free_prev (nbr_free_prev),
    .nbr_free_next (nbr_free_next)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // random back-pressure while a stall window is open, else always ready
  always @(negedge clk) begin
    int rnd;
    if (stall_left > 0) begin
      rnd = $random(seed);
      out_rdy = rnd[num_ports-1:0];
      stall_left--;
    end else begin
      out_rdy = '1;
    end
  end

  function automatic logic [msg_nbits-1:0] make_msg(int idx);
    logic [msg_nbits-1:0] m;
    m = '0;
    m[dest_lsb +: dest_nbits]     = c_dest[idx];
    m[src_lsb +: src_nbits]       = c_src[idx];
    m[opaque_lsb +: opaque_nbits] = c_opq[idx];
    m[payload_nbits-1:0]          = c_pay[idx];
    return m;
  endfunction

  // output a flit should take, -1 while the current counts hold it back
  function automatic int expect_out(int port, int dest, int fp, int fn);
    int up;
    int route;
    if (dest == my_id) begin
      return route_term;
    end
    // transit keeps its direction and needs one free slot
    if (port == route_prev) begin
      return (fn > 0) ? route_next : -1;
    end
    if (port == route_next) begin
      return (fp > 0) ? route_prev : -1;
    end
    // terminal flit, shorter way round, halfway goes next unless prev has more room
    up = (dest - my_id + num_routers) % num_routers;
    if (2 * up < num_routers) begin
      route = route_next;
    end else if (2 * up > num_routers) begin
      route = route_prev;
    end else begin
      route = (fp > fn) ? route_prev : route_next;
    end
    // injection must leave two free slots downstream
    if (route == route_next) begin
      return (fn > 1) ? route : -1;
    end
    return (fp > 1) ? route : -1;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < num_ports; i++) begin
      n += exp_msg[i].size() + held[i].size();
    end
    return n;
  endfunction

  function automatic int held_count();
    int n;
    n = 0;
    for (int i = 0; i < num_ports; i++) begin
      n += held[i].size();
    end
    return n;
  endfunction

  task automatic compare_msg(input string name, input logic [msg_nbits-1:0] got,
                             input logic [msg_nbits-1:0] exp, inout bit ok);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic compare_port(input string name, input logic [1:0] got,
                              input logic [1:0] exp, inout bit ok);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic expect_flit(int idx, int o);
    int p;
    p = c_port[idx];
    exp_msg[p].push_back(make_msg(idx));
    exp_port[p].push_back(2'(o));
    exp_case[p].push_back(idx);
  endtask

  // anything behind a parked flit stays parked too
  task automatic schedule(int idx);
    int p;
    int o;
    p = c_port[idx];
    o = expect_out(p, c_dest[idx], cur_fp, cur_fn);
    if (held[p].size() > 0 || o < 0) begin
      held[p].push_back(idx);
    end else begin
      expect_flit(idx, o);
    end
  endtask

  // new counts may free parked heads
  task automatic release_held();
    int idx;
    int o;
    for (int p = 0; p < num_ports; p++) begin
      while (held[p].size() > 0) begin
        idx = held[p][0];
        o = expect_out(p, c_dest[idx], cur_fp, cur_fn);
        if (o < 0) begin
          break;
        end
        idx = held[p].pop_front();
        expect_flit(idx, o);
      end
    end
  endtask

  task automatic check_output(int o, logic [msg_nbits-1:0] m);
    int src;
    int idx;
    bit ok;
    src = -1;
    ok = 1'b1;
    // the head of one input should match exactly
    for (int i = 0; i < num_ports; i++) begin
      if (src < 0 && exp_msg[i].size() > 0 && exp_msg[i][0] == m) begin
        src = i;
      end
    end
    // else blame the oldest head meant for this output
    for (int i = 0; i < num_ports; i++) begin
      if (src < 0 && exp_port[i].size() > 0 && exp_port[i][0] == o) begin
        src = i;
      end
    end
    if (src < 0) begin
      $display("error at %0t: unexpected flit %h on output %0d", $time, m, o);
      errors++;
      return;
    end
    idx = exp_case[src].pop_front();
    compare_msg($sformatf("out_msg_p%0d", o), m, exp_msg[src].pop_front(), ok);
    compare_port($sformatf("output of case %0d", idx), 2'(o), exp_port[src].pop_front(), ok);
    delivered++;
    $display("case %0d: input %0d -> output %0d payload %h %s",
             idx, src, o, m[payload_nbits-1:0], ok ? "ok" : "bad");
  endtask

  // transfers complete on the rising edge
  always @(posedge clk) begin
    if (arst_n) begin
      for (int o = 0; o < num_ports; o++) begin
        if (out_val[o] && out_rdy[o]) begin
          check_output(o, out_msg[o]);
        end
      end
    end
  end

  task automatic load_cases();
    int    fd;
    int    n;
    int    f [8];
    string line;
    fd = $fopen("tb/ring_router_cases.txt", "r");
    if (fd == 0) begin
      $display("error: the case file could not be opened");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%d %d %d %d %h %d %d %d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (n == 8) begin
          c_port.push_back(f[0]);
          c_dest.push_back(f[1]);
          c_src.push_back(f[2]);
          c_opq.push_back(f[3]);
          c_pay.push_back(f[4]);
          c_fp.push_back(f[5]);
          c_fn.push_back(f[6]);
          c_stall.push_back(f[7]);
        end
      end
    end
    $fclose(fd);
    if (c_port.size() == 0) begin
      $display("error: the case file holds no cases");
      aborted = 1'b1;
    end
  endtask

  // push this input's cases of the batch, holding val until each is taken
  task automatic drive_port(int p, int first, int last);
    int n;
    bit took;
    for (int k = first; k <= last; k++) begin
      if (c_port[k] == p && !aborted) begin
        @(negedge clk);
        in_val[p] = 1'b1;
        in_msg[p] = make_msg(k);
        took = 1'b0;
        n = 0;
        while (!took && n < wait_max) begin
          @(posedge clk);
          took = in_rdy[p];
          n++;
        end
        if (!took) begin
          $display("error: input %0d did not take case %0d within %0d cycles", p, k, wait_max);
          aborted = 1'b1;
        end
      end
    end
    @(negedge clk);
    in_val[p] = 1'b0;
  endtask

  // wait for the scoreboard to empty, then watch parked flits stay put
  task automatic drain();
    int n;
    n = 0;
    while (pending_count() > held_count() && n < wait_max) begin
      @(negedge clk);
      n++;
    end
    if (pending_count() > held_count()) begin
      $display("error: %0d flits not delivered within %0d cycles",
               pending_count() - held_count(), wait_max);
      aborted = 1'b1;
    end else if (held_count() > 0) begin
      n = 0;
      while (n < quiet_len) begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  // consecutive lines with equal counts form one batch, injected in parallel
  task automatic run_cases();
    int first;
    int last;
    int stall;
    first = 0;
    while (first < c_port.size() && !aborted) begin
      last = first;
      stall = c_stall[first];
      while (last + 1 < c_port.size() && c_fp[last+1] == c_fp[first] &&
             c_fn[last+1] == c_fn[first]) begin
        last++;
        if (c_stall[last] > stall) begin
          stall = c_stall[last];
        end
      end
      @(posedge clk);
      stall_left = stall;
      @(negedge clk);
      cur_fp = c_fp[first];
      cur_fn = c_fn[first];
      nbr_free_prev = free_nbits'(cur_fp);
      nbr_free_next = free_nbits'(cur_fn);
      release_held();
      for (int k = first; k <= last; k++) begin
        schedule(k);
      end
      fork
        drive_port(route_prev, first, last);
        drive_port(route_term, first, last);
        drive_port(route_next, first, last);
      join
      if (!aborted) begin
        drain();
      end
      first = last + 1;
    end
  endtask

  initial begin
    arst_n = 1'b0;
    for (int p = 0; p < num_ports; p++) begin
      in_val[p] = 1'b0;
      in_msg[p] = '0;
    end
    out_rdy = '1;
    nbr_free_prev = '1;
    nbr_free_next = '1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // idle after reset: queues empty and accepting, nothing offered
    for (int p = 0; p < num_ports; p++) begin
      if (in_rdy[p] !== 1'b1 || out_val[p] !== 1'b0) begin
        $display("error: port %0d not idle after reset", p);
        errors++;
      end
    end
    load_cases();
    if (!aborted) begin
      run_cases();
    end
    if (!aborted && held_count() > 0) begin
      $display("error: %0d flits still held by the bubble rule at the end", held_count());
      errors++;
    end
    $display("cases %0d, delivered %0d, errors %0d", c_port.size(), delivered, errors);
    if (errors == 0 && !aborted) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/net_msg_pkg.sv
rtl/router_cfg_pkg.sv
rtl/input_queue.sv
rtl/adaptive_route_compute.sv
rtl/input_terminal_ctrl.sv
rtl/input_ring_ctrl.sv
rtl/switch_alloc.sv
rtl/ring_router.sv
tb/ring_router_properties.sv
tb/ring_router_tb.sv

// ==== tb/ring_router_cases.txt ====
# port dest src opaque payload(hex) free_prev free_next stall
# port 0 prev, 1 term, 2 next; stall is cycles of random out_rdy
1 3 2 0 a1 3 3 0
1 0 2 1 a2 3 3 0
1 6 2 2 a3 3 2 0
1 6 2 3 a4 2 3 0
1 3 2 0 b1 3 1 0
0 5 1 1 b2 3 1 0
0 2 1 2 c1 3 3 0
2 2 4 3 c2 3 3 0
2 0 4 0 c3 3 3 0
0 6 1 1 c4 3 3 0
1 3 2 0 d1 3 2 40
1 0 2 1 d2 3 2 40
1 3 2 2 d3 3 2 40
1 2 2 3 d4 3 2 40
0 4 1 0 d5 3 2 40
0 4 1 1 d6 3 2 40
0 2 1 2 d7 3 2 40
2 1 3 0 d8 3 2 40
2 1 3 1 d9 3 2 40
0 2 1 0 e1 2 2 0
1 2 2 1 e2 2 2 0
2 2 3 2 e3 2 2 0
